// File: vlog.f
+incdir+common
common/l2_pkg.sv
common/line_access_if.sv
logic/way_victim_select.sv
l2_cache/l2_line_store.sv
l2_cache/l2_controller.sv
l2_cache/l2_cache.sv
verification/l2_mem_model.sv
verification/l2_cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the L2 cache testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module l2_cache_tb \
	-Mdir build \
	-o l2_cache_sim \
	> build/compile.log 2>&1 \
	|| { echo "compile failed, see build/compile.log"; exit 1; }

./build/l2_cache_sim > build/sim.log 2>&1 \
	|| { echo "simulation exited with an error, see build/sim.log"; exit 1; }

grep -qx "=== PASS ===" build/sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see build/sim.log"; exit 1; }

// File: verification/l2_cache_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache testbench
// Table of client reads against a memory model, data checked per beat
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "l2_macros.svh"

module l2_cache_tb import l2_pkg::*; ();

	localparam int N_TESTS = 19;
	localparam int TIMEOUT = 400;

	// One client read: refill means a memory burst is expected
	typedef struct {
		logic [31:0] addr;
		logic [7:0] len;
		burst_e burst;
		bit refill;
		bit bp;
		bit stall;
		bit fence_first;
	} entry_t;

	entry_t tests [N_TESTS];

	logic CLK;
	logic rst_n;
	logic fence;
	logic [`L2_ADDR_W-1:0] l1_araddr;
	logic [7:0] l1_arlen;
	logic [1:0] l1_arburst;
	logic l1_arvalid;
	logic l1_arready;
	logic [`L2_BEAT_W-1:0] l1_rdata;
	logic [1:0] l1_rresp;
	logic l1_rlast;
	logic l1_rvalid;
	logic l1_rready;
	logic [`L2_ADDR_W-1:0] mem_araddr;
	logic [7:0] mem_arlen;
	logic [1:0] mem_arburst;
	logic mem_arvalid;
	logic mem_arready;
	logic [`L2_BEAT_W-1:0] mem_rdata;
	logic [1:0] mem_rresp;
	logic mem_rlast;
	logic mem_rvalid;
	logic mem_rready;

	logic bp_en;
	logic stall_en;
	logic [2:0] rnd_bits;
	logic [31:0] lfsr_q = 32'hc3a1_feba;
	int mem_ar_count;
	logic [`L2_ADDR_W-1:0] mem_last_araddr;
	logic [7:0] mem_last_arlen;
	logic [1:0] mem_last_arburst;
	int errors;
	int passed;
	int failed;
	bit timed_out;

	l2_cache i_l2_cache (
		.CLK(CLK), .rst_n(rst_n), .fence(fence),
		.l1_araddr(l1_araddr), .l1_arlen(l1_arlen), .l1_arburst(l1_arburst),
		.l1_arvalid(l1_arvalid), .l1_arready(l1_arready),
		.l1_rdata(l1_rdata), .l1_rresp(l1_rresp), .l1_rlast(l1_rlast),
		.l1_rvalid(l1_rvalid), .l1_rready(l1_rready),
		.mem_araddr(mem_araddr), .mem_arlen(mem_arlen), .mem_arburst(mem_arburst),
		.mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
		.mem_rdata(mem_rdata), .mem_rresp(mem_rresp), .mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid), .mem_rready(mem_rready)
	);

	l2_mem_model i_mem (
		.CLK(CLK), .rst_n(rst_n),
		.mem_araddr(mem_araddr), .mem_arlen(mem_arlen), .mem_arburst(mem_arburst),
		.mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
		.mem_rdata(mem_rdata), .mem_rresp(mem_rresp), .mem_rlast(mem_rlast),
		.mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
		.stall_en(stall_en), .stall_bits(rnd_bits[2:1]),
		.ar_count(mem_ar_count), .last_araddr(mem_last_araddr),
		.last_arlen(mem_last_arlen), .last_arburst(mem_last_arburst)
	);

	always #4 CLK = ~CLK;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Three fresh bits per cycle, one LFSR step each
	always @(posedge CLK) begin
		#1;
		lfsr_q = lfsr_next(lfsr_q);
		rnd_bits = {rnd_bits[1:0], lfsr_q[0]};
		lfsr_q = lfsr_next(lfsr_q);
		rnd_bits = {rnd_bits[1:0], lfsr_q[0]};
		lfsr_q = lfsr_next(lfsr_q);
		rnd_bits = {rnd_bits[1:0], lfsr_q[0]};
	end

	assign l1_rready = bp_en ? rnd_bits[0] : 1'b1;

	task automatic next_cycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic report_mismatch(input string sig, input logic [63:0] got,
		input logic [63:0] exp);
		$display("FAIL t=%0t %s got %h expected %h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic load_table();
		// Cold miss, hit, partial INCR, FIXED, all in set 0
		tests[0] = '{32'h0000_1000, 8'd7, INCR, 1'b1, 1'b0, 1'b0, 1'b0};
		tests[1] = '{32'h0000_1000, 8'd7, INCR, 1'b0, 1'b0, 1'b0, 1'b0};
		tests[2] = '{32'h0000_1018, 8'd2, INCR, 1'b0, 1'b0, 1'b0, 1'b0};
		tests[3] = '{32'h0000_1028, 8'd3, FIXED, 1'b0, 1'b0, 1'b0, 1'b0};
		// Client back-pressure, miss then hit
		tests[4] = '{32'h0000_2040, 8'd7, INCR, 1'b1, 1'b1, 1'b0, 1'b0};
		tests[5] = '{32'h0000_2040, 8'd7, INCR, 1'b0, 1'b1, 1'b0, 1'b0};
		// Four tags in set 2 fill all ways
		tests[6] = '{32'h0001_0080, 8'd7, INCR, 1'b1, 1'b0, 1'b0, 1'b0};
		tests[7] = '{32'h0001_0880, 8'd7, INCR, 1'b1, 1'b0, 1'b0, 1'b0};
		tests[8] = '{32'h0001_1080, 8'd7, INCR, 1'b1, 1'b0, 1'b0, 1'b0};
		tests[9] = '{32'h0001_1880, 8'd7, INCR, 1'b1, 1'b0, 1'b0, 1'b0};
		tests[10] = '{32'h0001_0080, 8'd7, INCR, 1'b0, 1'b0, 1'b0, 1'b0};
		tests[11] = '{32'h0001_0880, 8'd7, INCR, 1'b0, 1'b0, 1'b0, 1'b0};
		tests[12] = '{32'h0001_1080, 8'd7, INCR, 1'b0, 1'b0, 1'b0, 1'b0};
		tests[13] = '{32'h0001_1880, 8'd7, INCR, 1'b0, 1'b0, 1'b0, 1'b0};
		// Fence drops every line
		tests[14] = '{32'h0001_0880, 8'd7, INCR, 1'b1, 1'b0, 1'b0, 1'b1};
		tests[15] = '{32'h0001_1880, 8'd7, INCR, 1'b1, 1'b0, 1'b0, 1'b0};
		// Memory stalls, with and without client back-pressure
		tests[16] = '{32'h0004_0100, 8'd7, INCR, 1'b1, 1'b0, 1'b1, 1'b0};
		tests[17] = '{32'h0005_0030, 8'd1, INCR, 1'b1, 1'b1, 1'b1, 1'b0};
		tests[18] = '{32'h0004_0120, 8'd2, FIXED, 1'b0, 1'b1, 1'b1, 1'b0};
	endtask

	task automatic run_entry(input int idx);
		entry_t e;
		int errs_before;
		int start_cnt;
		int cycles;
		int beats;
		int beat_idx;
		bit got_ar;
		bit held;
		logic [63:0] held_data;
		logic held_last;
		logic [31:0] line_base;
		logic [31:0] a;
		logic [63:0] exp_data;
		logic exp_last;
		e = tests[idx];
		errs_before = errors;
		start_cnt = mem_ar_count;
		line_base = {e.addr[31:6], 6'b0};
		bp_en = e.bp;
		stall_en = e.stall;
		if (e.fence_first) begin
			fence = 1'b1;
			next_cycle();
			fence = 1'b0;
		end
		l1_araddr = e.addr;
		l1_arlen = e.len;
		l1_arburst = e.burst;
		l1_arvalid = 1'b1;
		// Address phase, covers lookup and any refill
		got_ar = 1'b0;
		cycles = 0;
		while (!got_ar && cycles < TIMEOUT) begin
			@(negedge CLK);
			got_ar = l1_arready;
			next_cycle();
			cycles++;
		end
		l1_arvalid = 1'b0;
		if (!got_ar) begin
			$display("test %0d timed out waiting for l1_arready", idx);
			timed_out = 1'b1;
			return;
		end
		// Data phase, one check per transfer
		beats = 0;
		cycles = 0;
		held = 1'b0;
		while (beats <= int'(e.len) && cycles < TIMEOUT) begin
			@(negedge CLK);
			// A stalled beat must stay put
			if (held) begin
				if (!l1_rvalid) report_mismatch("l1_rvalid", 64'(l1_rvalid), 64'd1);
				if (l1_rdata !== held_data) report_mismatch("l1_rdata", l1_rdata, held_data);
				if (l1_rlast !== held_last) begin
					report_mismatch("l1_rlast", 64'(l1_rlast), 64'(held_last));
				end
			end
			held = l1_rvalid && !l1_rready;
			held_data = l1_rdata;
			held_last = l1_rlast;
			if (l1_rvalid && l1_rready) begin
				beat_idx = (e.burst == FIXED) ? int'(e.addr[5:3]) : int'(e.addr[5:3]) + beats;
				a = line_base + 32'(beat_idx * 8);
				exp_data = {~a, a};
				exp_last = (beats == int'(e.len));
				if (l1_rdata !== exp_data) report_mismatch("l1_rdata", l1_rdata, exp_data);
				if (l1_rlast !== exp_last) begin
					report_mismatch("l1_rlast", 64'(l1_rlast), 64'(exp_last));
				end
				if (l1_rresp !== 2'b00) report_mismatch("l1_rresp", 64'(l1_rresp), 64'd0);
				beats++;
			end
			next_cycle();
			cycles++;
		end
		if (beats <= int'(e.len)) begin
			$display("test %0d timed out after %0d of %0d beats", idx, beats, int'(e.len) + 1);
			timed_out = 1'b1;
			return;
		end
		// Exactly one line-aligned request on a miss, none on a hit
		if (mem_ar_count - start_cnt != (e.refill ? 1 : 0)) begin
			report_mismatch("mem ar count", 64'(mem_ar_count - start_cnt), 64'(e.refill));
		end
		if (e.refill && mem_last_araddr !== line_base) begin
			report_mismatch("mem_araddr", 64'(mem_last_araddr), 64'(line_base));
		end
		// Refill is always a whole-line INCR burst of eight beats
		if (e.refill && mem_last_arlen !== 8'd7) begin
			report_mismatch("mem_arlen", 64'(mem_last_arlen), 64'd7);
		end
		if (e.refill && mem_last_arburst !== INCR) begin
			report_mismatch("mem_arburst", 64'(mem_last_arburst), 64'(INCR));
		end
		if (errors == errs_before) begin
			passed++;
		end else begin
			failed++;
		end
		$display("test %0d %s addr %h len %0d: %s", idx, e.burst.name(), e.addr, e.len,
			(errors == errs_before) ? "ok" : "mismatch");
	endtask

	initial begin
		CLK = 1'b0;
		rst_n = 1'b0;
		fence = 1'b0;
		l1_araddr = '0;
		l1_arlen = '0;
		l1_arburst = 2'b01;
		l1_arvalid = 1'b0;
		bp_en = 1'b0;
		stall_en = 1'b0;
		rnd_bits = '0;
		errors = 0;
		passed = 0;
		failed = 0;
		timed_out = 1'b0;
		load_table();
		repeat (5) @(posedge CLK);
		#1;
		rst_n = 1'b1;
		next_cycle();
		for (int i = 0; i < N_TESTS && !timed_out; i++) begin
			run_entry(i);
		end
		$display("%0d tests passed, %0d failed, %0d check errors", passed, failed, errors);
		if (errors == 0 && !timed_out && passed == N_TESTS) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: verification/l2_mem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory responder for the L2 refill channel
// Answers line bursts, beat data is {~addr, addr}, optional random stalls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "l2_macros.svh"

module l2_mem_model (
	input  logic CLK,
	input  logic rst_n,
	input  logic [`L2_ADDR_W-1:0] mem_araddr,
	input  logic [7:0] mem_arlen,
	input  logic [1:0] mem_arburst,
	input  logic mem_arvalid,
	output logic mem_arready,
	output logic [`L2_BEAT_W-1:0] mem_rdata,
	output logic [1:0] mem_rresp,
	output logic mem_rlast,
	output logic mem_rvalid,
	input  logic mem_rready,
	// Random gap bits from the testbench LFSR, bit 0 for ARREADY, bit 1 for RVALID
	input  logic stall_en,
	input  logic [1:0] stall_bits,
	output int ar_count,
	output logic [`L2_ADDR_W-1:0] last_araddr,
	output logic [7:0] last_arlen,
	output logic [1:0] last_arburst
);

	logic busy;
	logic [7:0] beat;
	logic [7:0] last_beat;
	logic [`L2_ADDR_W-1:0] cur_addr;
	// Values seen at the falling edge, acted on after the next rising edge
	logic ar_fire;
	logic r_fire;
	logic in_reset;
	logic gaps_on;
	logic [1:0] gap;
	logic [`L2_ADDR_W-1:0] ar_addr_s;
	logic [7:0] ar_len_s;
	logic [1:0] ar_burst_s;

	initial begin
		mem_arready = 1'b0;
		mem_rdata = '0;
		mem_rresp = 2'b00;
		mem_rlast = 1'b0;
		mem_rvalid = 1'b0;
		ar_count = 0;
		last_araddr = '0;
		last_arlen = '0;
		last_arburst = '0;
		busy = 1'b0;
		beat = '0;
		last_beat = '0;
		cur_addr = '0;
		forever begin
			@(negedge CLK);
			ar_fire = mem_arvalid && mem_arready;
			r_fire = mem_rvalid && mem_rready;
			in_reset = !rst_n;
			gaps_on = stall_en;
			gap = stall_bits;
			ar_addr_s = mem_araddr;
			ar_len_s = mem_arlen;
			ar_burst_s = mem_arburst;
			@(posedge CLK);
			#1;
			if (in_reset) begin
				busy = 1'b0;
			end else begin
				// Beat taken, step to the next address of the burst
				if (r_fire) begin
					if (beat == last_beat) begin
						busy = 1'b0;
					end
					beat = beat + 8'd1;
					cur_addr = cur_addr + 32'd8;
				end
				if (ar_fire) begin
					ar_count = ar_count + 1;
					last_araddr = ar_addr_s;
					last_arlen = ar_len_s;
					last_arburst = ar_burst_s;
					cur_addr = ar_addr_s;
					last_beat = ar_len_s;
					beat = '0;
					busy = 1'b1;
				end
			end
			// One burst at a time
			mem_arready = !busy && (!gaps_on || gap[0]);
			mem_rvalid = busy && (!gaps_on || gap[1]);
			mem_rdata = {~cur_addr, cur_addr};
			mem_rlast = busy && (beat == last_beat);
		end
	end

endmodule

// File: l2_cache/l2_cache.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Read-only four-way L2 cache top level
// One client read channel in, one line refill read channel out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "l2_macros.svh"

module l2_cache (
	input  logic CLK,
	input  logic rst_n,
	input  logic fence,

	// Client read address
	input  logic [`L2_ADDR_W-1:0] l1_araddr,
	input  logic [7:0] l1_arlen,
	input  logic [1:0] l1_arburst,
	input  logic l1_arvalid,
	output logic l1_arready,

	// Client read data
	output logic [`L2_BEAT_W-1:0] l1_rdata,
	output logic [1:0] l1_rresp,
	output logic l1_rlast,
	output logic l1_rvalid,
	input  logic l1_rready,

	// Memory read address
	output logic [`L2_ADDR_W-1:0] mem_araddr,
	output logic [7:0] mem_arlen,
	output logic [1:0] mem_arburst,
	output logic mem_arvalid,
	input  logic mem_arready,

	// Memory read data
	input  logic [`L2_BEAT_W-1:0] mem_rdata,
	input  logic [1:0] mem_rresp,
	input  logic mem_rlast,
	input  logic mem_rvalid,
	output logic mem_rready
);

	// Controller to store link
	line_access_if i_line_if ();

	// FSM and both bus channels, port names match the top
	l2_controller i_controller (
		.line(i_line_if.ctrl),
		.*
	);

	// Tags, valid bits, data array
	l2_line_store i_line_store (
		.CLK(CLK),
		.rst_n(rst_n),
		.line(i_line_if.store)
	);

endmodule

// File: l2_cache/l2_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache controller
// Sequences lookup, allocation, line refill and the client response
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "l2_macros.svh"

module l2_controller import l2_pkg::*; (
	input  logic CLK,
	input  logic rst_n,
	input  logic fence,
	input  logic [`L2_ADDR_W-1:0] l1_araddr,
	input  logic [7:0] l1_arlen,
	input  logic [1:0] l1_arburst,
	input  logic l1_arvalid,
	output logic l1_arready,
	output logic [`L2_BEAT_W-1:0] l1_rdata,
	output logic [1:0] l1_rresp,
	output logic l1_rlast,
	output logic l1_rvalid,
	input  logic l1_rready,
	output logic [`L2_ADDR_W-1:0] mem_araddr,
	output logic [7:0] mem_arlen,
	output logic [1:0] mem_arburst,
	output logic mem_arvalid,
	input  logic mem_arready,
	input  logic [`L2_BEAT_W-1:0] mem_rdata,
	input  logic [1:0] mem_rresp,
	input  logic mem_rlast,
	input  logic mem_rvalid,
	output logic mem_rready,
	line_access_if.ctrl line
);

	l2_state_e state_q;
	l2_state_e state_d;

	// Latched client request
	logic [`L2_ADDR_W-1:0] req_addr_q;
	logic [7:0] req_len_q;
	burst_e req_burst_q;

	// Response side: beats loaded so far, beat index last read
	logic [7:0] rsp_cnt_q;
	logic [`L2_BEAT_IDX_W-1:0] rd_beat_q;
	logic [`L2_BEAT_IDX_W-1:0] next_beat;
	logic inflight_q;
	logic rvalid_q;
	logic rlast_q;
	logic [`L2_BEAT_W-1:0] rdata_q;

	// Refill side
	logic [`L2_BEAT_IDX_W-1:0] refill_cnt_q;
	logic mem_arvalid_q;
	logic fence_pend_q;

	logic lookup_hit;
	logic lookup_miss;
	logic out_load;
	logic more_beats;
	logic mem_beat;
	logic l1_done;
	logic [8:0] burst_end;

	assign lookup_hit = (state_q == LOOKUP) && line.hit;
	assign lookup_miss = (state_q == LOOKUP) && !line.hit;
	assign mem_beat = mem_rvalid && mem_rready;
	assign l1_done = rvalid_q && l1_rready && rlast_q;

	// Output slot free or draining this cycle, and a beat waiting in the store
	assign out_load = (state_q == RESPOND) && inflight_q && (!rvalid_q || l1_rready);
	assign more_beats = (rsp_cnt_q != req_len_q);

	// FIXED repeats the start beat, INCR and WRAP step inside the line
	assign next_beat = (req_burst_q == FIXED) ? rd_beat_q : rd_beat_q + 1'b1;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (fence_pend_q) begin
					state_d = FENCE;
				end else if (l1_arvalid) begin
					state_d = LOOKUP;
				end
			end
			LOOKUP: begin
				state_d = line.hit ? RESPOND : REFILL;
			end
			REFILL: begin
				// Tags again once the last beat is in
				if (mem_beat && mem_rlast) begin
					state_d = LOOKUP;
				end
			end
			RESPOND: begin
				if (l1_done) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state_q <= IDLE;
			fence_pend_q <= 1'b0;
			mem_arvalid_q <= 1'b0;
			refill_cnt_q <= '0;
			rsp_cnt_q <= '0;
			rd_beat_q <= '0;
			inflight_q <= 1'b0;
			rvalid_q <= 1'b0;
			rlast_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Fence waits for the next idle slot
			if (fence) begin
				fence_pend_q <= 1'b1;
			end else if (state_q == FENCE) begin
				fence_pend_q <= 1'b0;
			end
			// Refill request, held until memory takes it
			if (lookup_miss) begin
				mem_arvalid_q <= 1'b1;
			end else if (mem_arready) begin
				mem_arvalid_q <= 1'b0;
			end
			if (lookup_miss) begin
				refill_cnt_q <= '0;
			end else if (mem_beat) begin
				refill_cnt_q <= refill_cnt_q + 1'b1;
			end
			if (lookup_hit) begin
				rsp_cnt_q <= '0;
			end else if (out_load) begin
				rsp_cnt_q <= rsp_cnt_q + 1'b1;
			end
			if (line.beat_rd) begin
				rd_beat_q <= line.beat_sel;
			end
			// One beat in flight between store and output slot
			if (line.beat_rd) begin
				inflight_q <= 1'b1;
			end else if (out_load) begin
				inflight_q <= 1'b0;
			end
			if (out_load) begin
				rvalid_q <= 1'b1;
				rlast_q <= !more_beats;
			end else if (rvalid_q && l1_rready) begin
				rvalid_q <= 1'b0;
				rlast_q <= 1'b0;
			end
		end
	end

	// Request and data payload
	always_ff @(posedge CLK) begin
		if (state_q == IDLE && !fence_pend_q && l1_arvalid) begin
			req_addr_q <= l1_araddr;
			req_len_q <= l1_arlen;
			req_burst_q <= burst_e'(l1_arburst);
		end
		if (out_load) begin
			rdata_q <= line.beat_data;
		end
	end

	// Store side
	assign line.state = state_q;
	assign line.lookup_addr = req_addr_q;
	assign line.alloc = lookup_miss;
	assign line.beat_rd = lookup_hit || (out_load && more_beats);
	assign line.beat_sel = (state_q == REFILL) ? refill_cnt_q :
		(state_q == LOOKUP) ? req_addr_q[`L2_BEAT_LSB +: `L2_BEAT_IDX_W] : next_beat;
	assign line.fill_we = (state_q == REFILL) && mem_beat;
	assign line.fill_data = mem_rdata;
	assign line.flush = (state_q == FENCE);

	// Client channel, always OKAY
	assign l1_arready = lookup_hit;
	assign l1_rdata = rdata_q;
	assign l1_rresp = 2'b00;
	assign l1_rlast = rlast_q;
	assign l1_rvalid = rvalid_q;

	// Memory channel, whole line starting at beat 0
	assign mem_araddr = {req_addr_q[`L2_ADDR_W-1:`L2_INDEX_LSB], {(`L2_INDEX_LSB){1'b0}}};
	assign mem_arlen = 8'(`L2_LINE_BEATS - 1);
	assign mem_arburst = INCR;
	assign mem_arvalid = mem_arvalid_q;
	assign mem_rready = (state_q == REFILL);

	// Last beat index of the incoming burst
	assign burst_end = {6'd0, l1_araddr[`L2_BEAT_LSB +: `L2_BEAT_IDX_W]} + {1'b0, l1_arlen};

	a_mem_ar_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		mem_arvalid && !mem_arready |=> mem_arvalid);

	a_rlast_with_rvalid: assert property (@(posedge CLK) disable iff (!rst_n)
		l1_rlast |-> l1_rvalid);

	a_burst_in_line: assert property (@(posedge CLK) disable iff (!rst_n)
		state_q == IDLE && l1_arvalid && l1_arburst == INCR
		|-> burst_end < 9'(`L2_LINE_BEATS));

	// Memory is expected to answer OKAY on every fill beat
	a_mem_okay: assert property (@(posedge CLK) disable iff (!rst_n)
		line.fill_we |-> mem_rresp == 2'b00);

endmodule

// File: l2_cache/l2_line_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 line store
// Tag registers, valid bits, data array and parallel hit detection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "l2_macros.svh"

module l2_line_store import l2_pkg::*; (
	input logic CLK,
	input logic rst_n,
	line_access_if.store line
);

	logic [`L2_INDEX_W-1:0] set_idx;
	logic [`L2_TAG_W-1:0] req_tag;

	logic [`L2_TAG_W-1:0] tag_q [`L2_WAYS][`L2_SETS];
	logic [`L2_WAYS-1:0] valid_q [`L2_SETS];
	// Data array addressed as {way, set, beat}
	logic [`L2_BEAT_W-1:0] data_mem [`L2_WAYS*`L2_SETS*`L2_LINE_BEATS];
	logic [`L2_BEAT_W-1:0] beat_data_q;

	logic [`L2_WAYS-1:0] hit_vec;
	logic [`L2_WAY_W-1:0] hit_idx;
	logic [`L2_WAY_W-1:0] victim_way;
	logic [`L2_WAY_W-1:0] fill_way_q;

	assign set_idx = line.lookup_addr[`L2_INDEX_LSB +: `L2_INDEX_W];
	assign req_tag = line.lookup_addr[`L2_ADDR_W-1 -: `L2_TAG_W];

	// Victim from the valid bits of the addressed set
	way_victim_select i_victim (
		.CLK(CLK),
		.rst_n(rst_n),
		.set_valid(valid_q[set_idx]),
		.victim_way(victim_way)
	);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int s = 0; s < `L2_SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (line.flush) begin
			for (int s = 0; s < `L2_SETS; s++) begin
				valid_q[s] <= '0;
			end
		end else if (line.alloc) begin
			valid_q[set_idx][victim_way] <= 1'b1;
		end
	end

	// New tag goes in at allocation, the way is kept for the fill beats
	always_ff @(posedge CLK) begin
		if (line.alloc) begin
			tag_q[victim_way][set_idx] <= req_tag;
			fill_way_q <= victim_way;
		end
	end

	// All ways compared at once
	always_comb begin
		for (int w = 0; w < `L2_WAYS; w++) begin
			hit_vec[w] = valid_q[set_idx][w] && (tag_q[w][set_idx] == req_tag);
		end
	end

	assign line.hit_way = hit_vec;
	assign line.hit = |hit_vec;

	// One-hot hit to way index for the read port
	always_comb begin
		hit_idx = '0;
		for (int w = 0; w < `L2_WAYS; w++) begin
			if (line.hit_way[w]) begin
				hit_idx = w[`L2_WAY_W-1:0];
			end
		end
	end

	// Synchronous data array, read data one cycle after beat_rd
	always_ff @(posedge CLK) begin
		if (line.fill_we) begin
			data_mem[{fill_way_q, set_idx, line.beat_sel}] <= line.fill_data;
		end
		if (line.beat_rd) begin
			beat_data_q <= data_mem[{hit_idx, set_idx, line.beat_sel}];
		end
	end

	assign line.beat_data = beat_data_q;

	a_hit_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
		$onehot0(line.hit_way));

	// Refill beats land in the way that now holds the requested tag
	a_fill_way_hit: assert property (@(posedge CLK) disable iff (!rst_n)
		line.state == REFILL |-> line.hit_way[fill_way_q]);

	// Reads only ever target a way that holds the line
	a_read_on_hit: assert property (@(posedge CLK) disable iff (!rst_n)
		line.beat_rd |-> line.hit);

endmodule

// File: logic/way_victim_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Way victim selection
// Lowest invalid way, else a pseudo-random way from a free-running LFSR
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "l2_macros.svh"

module way_victim_select (
	input  logic CLK,
	input  logic rst_n,
	input  logic [`L2_WAYS-1:0] set_valid,
	output logic [`L2_WAY_W-1:0] victim_way
);

	logic [15:0] lfsr_q;
	logic lfsr_fb;

	// x^16 + x^14 + x^13 + x^11, maximal length
	assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

	// Steps every cycle
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			lfsr_q <= 16'hace1;
		end else begin
			lfsr_q <= {lfsr_q[14:0], lfsr_fb};
		end
	end

	// Scan from the top so the lowest invalid way wins
	always_comb begin
		victim_way = lfsr_q[`L2_WAY_W-1:0];
		for (int i = `L2_WAYS - 1; i >= 0; i--) begin
			if (!set_valid[i]) begin
				victim_way = i[`L2_WAY_W-1:0];
			end
		end
	end

endmodule

// File: common/line_access_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Controller to line store link
// Lookup, way allocation, beat read and refill beat write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`include "l2_macros.svh"

interface line_access_if import l2_pkg::*; ();

	// Controller state, seen by the store checks
	l2_state_e state;
	// Address under test, also gives set and tag for fills
	logic [`L2_ADDR_W-1:0] lookup_addr;
	// Claim the victim way for the current address
	logic alloc;
	// Read one beat, data one cycle later
	logic beat_rd;
	logic [`L2_BEAT_IDX_W-1:0] beat_sel;
	// Refill beat into the allocated way
	logic fill_we;
	logic [`L2_BEAT_W-1:0] fill_data;
	// Invalidate the whole cache
	logic flush;
	// Store results
	logic hit;
	logic [`L2_WAYS-1:0] hit_way;
	logic [`L2_BEAT_W-1:0] beat_data;

	modport ctrl (
		output state, lookup_addr, alloc, beat_rd, beat_sel, fill_we, fill_data, flush,
		input hit, hit_way, beat_data
	);

	modport store (
		input state, lookup_addr, alloc, beat_rd, beat_sel, fill_we, fill_data, flush,
		output hit, hit_way, beat_data
	);

endinterface

// File: common/l2_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache shared types
// Controller states and AXI burst encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package l2_pkg;

	// Cache controller FSM
	typedef enum logic [2:0] {
		// Waiting for a client request or a fence
		IDLE    = 3'd0,
		// Tag compare on the latched address
		LOOKUP  = 3'd1,
		// Line fill from memory
		REFILL  = 3'd2,
		// Beats streamed to the client
		RESPOND = 3'd3,
		// One cycle of valid-bit clear
		FENCE   = 3'd4
	} l2_state_e;

	// AXI burst type, same encoding as ARBURST
	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} burst_e;

endpackage

// File: common/l2_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// L2 cache geometry and bus widths
// Four ways, 32 sets, 64-byte lines of eight 64-bit beats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef L2_MACROS_SVH
`define L2_MACROS_SVH

// Bus widths
`define L2_ADDR_W 32
`define L2_BEAT_W 64

// Associativity and way index width
`define L2_WAYS 4
`define L2_WAY_W 2

// Sets and beats per line
`define L2_SETS 32
`define L2_LINE_BEATS 8
`define L2_BEAT_IDX_W 3

// Address fields: | tag | index | beat | byte |
`define L2_BEAT_LSB 3
`define L2_INDEX_LSB (`L2_BEAT_LSB + `L2_BEAT_IDX_W)
`define L2_INDEX_W 5
`define L2_TAG_W (`L2_ADDR_W - `L2_INDEX_LSB - `L2_INDEX_W)

`endif
